//--- build.f
store_pkg.sv
store_ifs.sv
store_queue.sv
store_align.sv
store_mem_ctrl.sv
store_unit_top.sv
tb_clkgen.sv
tb_store_unit.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_store_unit -o sim_store_unit
./obj_dir/sim_store_unit > sim.log
cat sim.log

if grep -qx "Done: no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- store_align.sv
`default_nettype none

module store_align
    import store_pkg::*;
#(
    parameter int rob_idx_w = 3
) (
    sq_entry_if.align entry,
    mem_req_if.align  req
);
    logic [xlen-1:0] addr;
    logic [3:0]      wmask;
    logic [xlen-1:0] wdata;

    assign addr = entry.entry_base + entry.entry_imm;

    always_comb begin
        wmask = 4'b0000;
        wdata = '0;
        case (entry.entry_funct)
            sb_mem: begin
                wmask = 4'b0001 << addr[1:0];
                wdata[8 * addr[1:0] +: 8] = entry.entry_data[7:0];
            end
            sh_mem: begin
                // halfword lanes only, addr[0] is ignored
                wmask = 4'b0011 << {addr[1], 1'b0};
                wdata[16 * addr[1] +: 16] = entry.entry_data[15:0];
            end
            sw_mem: begin
                wmask = 4'b1111;
                wdata = entry.entry_data;
            end
            default: begin
                wmask = 4'b0000;
                wdata = '0;
            end
        endcase
    end

    assign req.req_valid = entry.entry_rqst;
    assign req.req_addr  = addr;
    assign req.req_wmask = wmask;
    assign req.req_wdata = wdata;
    assign req.req_rob   = rob_idx_w'(entry.entry_rob);

endmodule

`default_nettype wire

//--- store_ifs.sv
`default_nettype none

// oldest queue entry, seen by the alignment stage
interface sq_entry_if
    import store_pkg::*;
#(
    parameter int rob_idx_w = 3
);
    logic                 entry_rqst;
    logic [xlen-1:0]      entry_base;
    logic [xlen-1:0]      entry_imm;
    store_funct_e         entry_funct;
    logic [xlen-1:0]      entry_data;
    logic [rob_idx_w-1:0] entry_rob;

    modport queue (
        output entry_rqst,
        output entry_base,
        output entry_imm,
        output entry_funct,
        output entry_data,
        output entry_rob
    );

    modport align (
        input entry_rqst,
        input entry_base,
        input entry_imm,
        input entry_funct,
        input entry_data,
        input entry_rob
    );
endinterface

// aligned write request towards the memory controller
interface mem_req_if
    import store_pkg::*;
#(
    parameter int rob_idx_w = 3
);
    logic                 req_valid;
    logic [xlen-1:0]      req_addr;
    logic [3:0]           req_wmask;
    logic [xlen-1:0]      req_wdata;
    logic [rob_idx_w-1:0] req_rob;

    modport align (
        output req_valid,
        output req_addr,
        output req_wmask,
        output req_wdata,
        output req_rob
    );

    modport ctrl (
        input req_valid,
        input req_addr,
        input req_wmask,
        input req_wdata,
        input req_rob
    );
endinterface

`default_nettype wire

//--- store_mem_ctrl.sv
`default_nettype none

module store_mem_ctrl
    import store_pkg::*;
#(
    parameter int rob_idx_w = 3
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 dmem_resp,

    mem_req_if.ctrl              req,

    output logic                 dmem_write,
    output logic [xlen-1:0]      dmem_addr,
    output logic [3:0]           dmem_wmask,
    output logic [xlen-1:0]      dmem_wdata,

    output logic                 sq_pop,
    output logic                 cdb_store_valid,
    output logic [rob_idx_w-1:0] cdb_store_rob
);
    // idle when low, one write outstanding when high
    logic busy;
    logic done;

    // a flushed store never completes
    assign done = busy && dmem_resp && !flush;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            busy <= 1'b0;
        end else if (!busy) begin
            busy <= req.req_valid;
        end else if (dmem_resp) begin
            busy <= 1'b0;
        end
    end

    // request held stable by the queue tail while busy
    assign dmem_write = busy;
    assign dmem_addr  = req.req_addr;
    assign dmem_wmask = req.req_wmask;
    assign dmem_wdata = req.req_wdata;

    assign sq_pop          = done;
    assign cdb_store_valid = done;
    assign cdb_store_rob   = req.req_rob;

endmodule

`default_nettype wire

//--- store_pkg.sv
`default_nettype none

package store_pkg;

    // data and address width
    localparam int xlen = 32;

    // funct3 of the RV32I store instructions
    typedef enum logic [2:0] {
        sb_mem = 3'b000,
        sh_mem = 3'b001,
        sw_mem = 3'b010
    } store_funct_e;

endpackage

`default_nettype wire

//--- store_queue.sv
`default_nettype none

module store_queue
    import store_pkg::*;
#(
    parameter int queue_depth_log2 = 3,
    parameter int rob_idx_w        = 3,
    parameter int cdb_ports        = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,

    input  logic                 sq_issue,
    input  store_funct_e         issue_funct,
    input  logic [xlen-1:0]      issue_imm,
    input  logic [rob_idx_w-1:0] issue_rob,
    input  logic [rob_idx_w-1:0] issue_rs1_tag,
    input  logic [rob_idx_w-1:0] issue_rs2_tag,
    input  logic                 issue_rs1_rf_ready,
    input  logic                 issue_rs2_rf_ready,
    input  logic                 issue_rs1_rob_ready,
    input  logic                 issue_rs2_rob_ready,
    input  logic [xlen-1:0]      issue_rs1_rf_value,
    input  logic [xlen-1:0]      issue_rs2_rf_value,
    input  logic [xlen-1:0]      issue_rs1_rob_value,
    input  logic [xlen-1:0]      issue_rs2_rob_value,

    input  logic [rob_idx_w-1:0] rob_tail,

    input  logic                 cdb_valid [cdb_ports],
    input  logic [rob_idx_w-1:0] cdb_rob   [cdb_ports],
    input  logic [xlen-1:0]      cdb_value [cdb_ports],

    input  logic                 sq_pop,
    output logic                 sq_full,

    sq_entry_if.queue            entry
);
    localparam int depth = 2 ** queue_depth_log2;

    // head is the next free slot, tail the oldest store
    logic [queue_depth_log2-1:0] head;
    logic [queue_depth_log2-1:0] tail;

    logic                 valid     [depth];
    logic                 rs1_ready [depth];
    logic                 rs2_ready [depth];
    logic [rob_idx_w-1:0] rs1_tag   [depth];
    logic [rob_idx_w-1:0] rs2_tag   [depth];
    logic [xlen-1:0]      rs1_value [depth];
    logic [xlen-1:0]      rs2_value [depth];
    logic [xlen-1:0]      imm       [depth];
    store_funct_e         funct     [depth];
    logic [rob_idx_w-1:0] target    [depth];

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < depth; i++) begin
                valid[i]     <= 1'b0;
                rs1_ready[i] <= 1'b0;
                rs2_ready[i] <= 1'b0;
            end
        end else begin
            // operand capture from the CDB, last matching port wins
            for (int i = 0; i < depth; i++) begin
                if (valid[i]) begin
                    for (int j = 0; j < cdb_ports; j++) begin
                        if (cdb_valid[j] && !rs1_ready[i] && (rs1_tag[i] == cdb_rob[j])) begin
                            rs1_ready[i] <= 1'b1;
                            rs1_value[i] <= cdb_value[j];
                        end
                        if (cdb_valid[j] && !rs2_ready[i] && (rs2_tag[i] == cdb_rob[j])) begin
                            rs2_ready[i] <= 1'b1;
                            rs2_value[i] <= cdb_value[j];
                        end
                    end
                end
            end

            if (sq_issue) begin
                valid[head]  <= 1'b1;
                funct[head]  <= issue_funct;
                imm[head]    <= issue_imm;
                target[head] <= issue_rob;
                rs1_tag[head] <= issue_rs1_tag;
                rs2_tag[head] <= issue_rs2_tag;

                // register file first, then the ROB
                rs1_ready[head] <= issue_rs1_rf_ready || issue_rs1_rob_ready;
                rs1_value[head] <= issue_rs1_rf_ready ? issue_rs1_rf_value
                                                      : issue_rs1_rob_value;
                rs2_ready[head] <= issue_rs2_rf_ready || issue_rs2_rob_ready;
                rs2_value[head] <= issue_rs2_rf_ready ? issue_rs2_rf_value
                                                      : issue_rs2_rob_value;
                head <= head + 1'b1;
            end

            if (sq_pop) begin
                valid[tail] <= 1'b0;
                tail        <= tail + 1'b1;
            end
        end
    end

    // wrapped around onto a live entry
    assign sq_full = valid[head];

    // oldest store may go once it heads the ROB
    assign entry.entry_rqst  = valid[tail] && rs1_ready[tail] && rs2_ready[tail]
                               && (target[tail] == rob_tail);
    assign entry.entry_base  = rs1_value[tail];
    assign entry.entry_imm   = imm[tail];
    assign entry.entry_funct = funct[tail];
    assign entry.entry_data  = rs2_value[tail];
    assign entry.entry_rob   = target[tail];

endmodule

`default_nettype wire

//--- store_unit_top.sv
`default_nettype none

module store_unit_top
    import store_pkg::*;
#(
    parameter int queue_depth_log2 = 3,
    parameter int rob_idx_w        = 3,
    parameter int cdb_ports        = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,

    input  logic                 sq_issue,
    input  store_funct_e         issue_funct,
    input  logic [xlen-1:0]      issue_imm,
    input  logic [rob_idx_w-1:0] issue_rob,
    input  logic [rob_idx_w-1:0] issue_rs1_tag,
    input  logic [rob_idx_w-1:0] issue_rs2_tag,
    input  logic                 issue_rs1_rf_ready,
    input  logic                 issue_rs2_rf_ready,
    input  logic                 issue_rs1_rob_ready,
    input  logic                 issue_rs2_rob_ready,
    input  logic [xlen-1:0]      issue_rs1_rf_value,
    input  logic [xlen-1:0]      issue_rs2_rf_value,
    input  logic [xlen-1:0]      issue_rs1_rob_value,
    input  logic [xlen-1:0]      issue_rs2_rob_value,
    output logic                 sq_full,

    input  logic [rob_idx_w-1:0] rob_tail,

    input  logic                 cdb_valid [cdb_ports],
    input  logic [rob_idx_w-1:0] cdb_rob   [cdb_ports],
    input  logic [xlen-1:0]      cdb_value [cdb_ports],

    input  logic                 dmem_resp,
    output logic                 dmem_write,
    output logic [xlen-1:0]      dmem_addr,
    output logic [3:0]           dmem_wmask,
    output logic [xlen-1:0]      dmem_wdata,

    output logic                 cdb_store_valid,
    output logic [rob_idx_w-1:0] cdb_store_rob
);
    logic sq_pop;

    sq_entry_if #(.rob_idx_w(rob_idx_w)) entry_bus ();
    mem_req_if  #(.rob_idx_w(rob_idx_w)) req_bus ();

    store_queue #(
        .queue_depth_log2 (queue_depth_log2),
        .rob_idx_w        (rob_idx_w),
        .cdb_ports        (cdb_ports)
    ) u_queue (
        .clk                 (clk),
        .rst_n               (rst_n),
        .flush               (flush),
        .sq_issue            (sq_issue),
        .issue_funct         (issue_funct),
        .issue_imm           (issue_imm),
        .issue_rob           (issue_rob),
        .issue_rs1_tag       (issue_rs1_tag),
        .issue_rs2_tag       (issue_rs2_tag),
        .issue_rs1_rf_ready  (issue_rs1_rf_ready),
        .issue_rs2_rf_ready  (issue_rs2_rf_ready),
        .issue_rs1_rob_ready (issue_rs1_rob_ready),
        .issue_rs2_rob_ready (issue_rs2_rob_ready),
        .issue_rs1_rf_value  (issue_rs1_rf_value),
        .issue_rs2_rf_value  (issue_rs2_rf_value),
        .issue_rs1_rob_value (issue_rs1_rob_value),
        .issue_rs2_rob_value (issue_rs2_rob_value),
        .rob_tail            (rob_tail),
        .cdb_valid           (cdb_valid),
        .cdb_rob             (cdb_rob),
        .cdb_value           (cdb_value),
        .sq_pop              (sq_pop),
        .sq_full             (sq_full),
        .entry               (entry_bus.queue)
    );

    store_align #(
        .rob_idx_w (rob_idx_w)
    ) u_align (
        .entry (entry_bus.align),
        .req   (req_bus.align)
    );

    store_mem_ctrl #(
        .rob_idx_w (rob_idx_w)
    ) u_mem_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush           (flush),
        .dmem_resp       (dmem_resp),
        .req             (req_bus.ctrl),
        .dmem_write      (dmem_write),
        .dmem_addr       (dmem_addr),
        .dmem_wmask      (dmem_wmask),
        .dmem_wdata      (dmem_wdata),
        .sq_pop          (sq_pop),
        .cdb_store_valid (cdb_store_valid),
        .cdb_store_rob   (cdb_store_rob)
    );

endmodule

`default_nettype wire

//--- tb_clkgen.sv
`default_nettype none

module tb_clkgen #(
    parameter int period       = 40,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rst_n
);
    initial clk = 1'b0;
    always #(period / 2) clk = ~clk;

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end
endmodule

`default_nettype wire

//--- tb_store_unit.sv
`default_nettype none

module tb_store_unit
    import store_pkg::*;
;
    localparam int stores    = 12 + 1 + 3 + 8 + 3 + 4;
    localparam int max_cycle = stores * 16 + 300;

    logic clk, rst_n, flush, sq_issue, sq_full, dmem_write;
    logic dmem_resp = 1'b0;
    logic cdb_store_valid, rs1_rf_rdy, rs2_rf_rdy, rs1_rob_rdy, rs2_rob_rdy;
    store_funct_e issue_funct;
    logic [31:0] issue_imm, rs1_rf_val, rs2_rf_val, rs1_rob_val, rs2_rob_val;
    logic [31:0] dmem_addr, dmem_wdata;
    logic [3:0]  dmem_wmask;
    logic [2:0]  issue_rob, rs1_tag, rs2_tag, cdb_store_rob, head_rob, issue_ctr;
    logic [2:0]  rob_tail = 3'd0;
    logic        cdb_valid [4];
    logic [2:0]  cdb_rob   [4];
    logic [31:0] cdb_value [4];
    // expected stores in issue order
    logic [31:0] exp_addr [64];
    logic [31:0] exp_data [64];
    logic [3:0]  exp_mask [64];
    logic [2:0]  exp_rob  [64];
    logic [1:0]  exp_lat  [64];
    logic [5:0]  rd_ptr, wr_ptr;
    logic [1:0]  wait_cnt = 2'd0;
    logic        stall, block;
    int          seed, errors, tests;
    int          cycles = 0;

    tb_clkgen #(.period(40), .reset_cycles(2)) u_clkgen (.clk(clk), .rst_n(rst_n));

    store_unit_top dut (
        .clk(clk), .rst_n(rst_n), .flush(flush), .sq_issue(sq_issue),
        .issue_funct(issue_funct), .issue_imm(issue_imm), .issue_rob(issue_rob),
        .issue_rs1_tag(rs1_tag), .issue_rs2_tag(rs2_tag),
        .issue_rs1_rf_ready(rs1_rf_rdy), .issue_rs2_rf_ready(rs2_rf_rdy),
        .issue_rs1_rob_ready(rs1_rob_rdy), .issue_rs2_rob_ready(rs2_rob_rdy),
        .issue_rs1_rf_value(rs1_rf_val), .issue_rs2_rf_value(rs2_rf_val),
        .issue_rs1_rob_value(rs1_rob_val), .issue_rs2_rob_value(rs2_rob_val),
        .sq_full(sq_full), .rob_tail(rob_tail), .cdb_valid(cdb_valid), .cdb_rob(cdb_rob),
        .cdb_value(cdb_value), .dmem_resp(dmem_resp), .dmem_write(dmem_write),
        .dmem_addr(dmem_addr), .dmem_wmask(dmem_wmask), .dmem_wdata(dmem_wdata),
        .cdb_store_valid(cdb_store_valid), .cdb_store_rob(cdb_store_rob)
    );

    task automatic report_mismatch(input string name, input logic [31:0] exp, act);
        errors++;
        $display("mismatch %s: expected %h, got %h", name, exp, act);
    endtask

    a_addr: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(dmem_write) |-> dmem_addr == exp_addr[rd_ptr])
        else report_mismatch("dmem_addr", $sampled(exp_addr[rd_ptr]), $sampled(dmem_addr));
    a_mask: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(dmem_write) |-> dmem_wmask == exp_mask[rd_ptr])
        else report_mismatch("dmem_wmask", 32'($sampled(exp_mask[rd_ptr])),
                             32'($sampled(dmem_wmask)));
    a_data: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(dmem_write) |-> dmem_wdata == exp_data[rd_ptr])
        else report_mismatch("dmem_wdata", $sampled(exp_data[rd_ptr]), $sampled(dmem_wdata));
    // oldest store goes only once the ROB reaches it
    a_order: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(dmem_write) |-> $past(rob_tail) == exp_rob[rd_ptr])
        else report_mismatch("rob_tail", 32'($sampled(exp_rob[rd_ptr])),
                             32'($sampled($past(rob_tail))));
    a_done: assert property (@(posedge clk) disable iff (!rst_n)
        cdb_store_valid |-> cdb_store_rob == exp_rob[rd_ptr])
        else report_mismatch("cdb_store_rob", 32'($sampled(exp_rob[rd_ptr])),
                             32'($sampled(cdb_store_rob)));
    // completion only in the response cycle of an active write
    a_resp: assert property (@(posedge clk) disable iff (!rst_n || flush)
        cdb_store_valid == (dmem_resp && dmem_write))
        else report_mismatch("cdb_store_valid", 32'($sampled(dmem_resp && dmem_write)),
                             32'($sampled(cdb_store_valid)));
    a_stable: assert property (@(posedge clk) disable iff (!rst_n || flush)
        dmem_write && $past(dmem_write) |-> $stable(dmem_addr) && $stable(dmem_wmask)
        && $stable(dmem_wdata))
        else begin errors++; $display("write request changed before the response"); end
    a_flush: assert property (@(posedge clk) disable iff (!rst_n) flush |=> !dmem_write)
        else begin errors++; $display("write still active after a flush"); end

    // responder, rob tail and model pointer
    always @(posedge clk) begin
        dmem_resp <= 1'b0;
        cycles    <= cycles + 1;
        if (!rst_n || flush || !dmem_write || stall) begin
            wait_cnt <= 2'd0;
        end else if (!dmem_resp) begin
            if (wait_cnt >= exp_lat[rd_ptr]) dmem_resp <= 1'b1;
            else wait_cnt <= wait_cnt + 2'd1;
        end
        if (!rst_n) begin
            head_rob <= 3'd0;
            rob_tail <= 3'd0;
            rd_ptr   <= 6'd0;
        end else begin
            if (flush) rd_ptr <= wr_ptr;
            else if (cdb_store_valid) rd_ptr <= rd_ptr + 6'd1;
            head_rob <= head_rob + 3'(cdb_store_valid);
            rob_tail <= head_rob + 3'(cdb_store_valid) + (block ? 3'd5 : 3'd0);
        end
        if (cycles == max_cycle) begin
            $display("timeout: run did not finish within %0d cycles", max_cycle);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic issue_store(input logic rs2_wait, input logic [31:0] data);
        logic [31:0] base, imm, addr;
        logic [2:0]  pick;
        logic        use_rob;
        base    = $random(seed);
        imm     = $random(seed);
        pick    = 3'(($random(seed) & 32'h7fff_ffff) % 3);
        use_rob = 1'($random(seed));
        addr    = base + imm;
        @(posedge clk);
        sq_issue    <= 1'b1;
        issue_funct <= store_funct_e'(pick);
        issue_imm   <= imm;
        issue_rob   <= issue_ctr;
        rs1_tag     <= 3'd0;
        rs2_tag     <= 3'd5;
        // register file wins when both are ready
        rs1_rf_rdy  <= !use_rob;
        rs1_rob_rdy <= 1'b1;
        rs1_rf_val  <= use_rob ? ~base : base;
        rs1_rob_val <= use_rob ? base : ~base;
        rs2_rf_rdy  <= !use_rob && !rs2_wait;
        rs2_rob_rdy <= !rs2_wait;
        rs2_rf_val  <= (use_rob || rs2_wait) ? ~data : data;
        rs2_rob_val <= (use_rob && !rs2_wait) ? data : ~data;
        case (pick)
            3'd0: begin
                exp_mask[wr_ptr] = 4'b0001 << addr[1:0];
                exp_data[wr_ptr] = {24'd0, data[7:0]} << (8 * addr[1:0]);
            end
            3'd1: begin
                exp_mask[wr_ptr] = addr[1] ? 4'b1100 : 4'b0011;
                exp_data[wr_ptr] = addr[1] ? {data[15:0], 16'd0} : {16'd0, data[15:0]};
            end
            default: begin
                exp_mask[wr_ptr] = 4'b1111;
                exp_data[wr_ptr] = data;
            end
        endcase
        exp_addr[wr_ptr] = addr;
        exp_rob[wr_ptr]  = issue_ctr;
        exp_lat[wr_ptr]  = 2'($random(seed));
        wr_ptr    = wr_ptr + 6'd1;
        issue_ctr = issue_ctr + 3'd1;
        @(posedge clk);
        sq_issue <= 1'b0;
    endtask

    task automatic drain();
        while (rd_ptr != wr_ptr) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic expect_low(input string name, input logic value);
        assert (value === 1'b0) else report_mismatch(name, 32'd0, 32'(value));
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        $display("test %s: %s", name, (errors == errors_before) ? "ok" : "failed");
    endtask

    initial begin
        int e;
        seed = 32'ha2f8_5023;
        {flush, sq_issue, stall, block, errors, tests, wr_ptr, issue_ctr} = '0;
        {rs1_rf_rdy, rs2_rf_rdy, rs1_rob_rdy, rs2_rob_rdy} = '0;
        {issue_imm, issue_rob, rs1_tag, rs2_tag} = '0;
        {rs1_rf_val, rs2_rf_val, rs1_rob_val, rs2_rob_val} = '0;
        issue_funct = sw_mem;
        for (int i = 0; i < 4; i++) begin
            cdb_valid[i] = 1'b0;
            cdb_rob[i]   = 3'd0;
            cdb_value[i] = '0;
        end
        @(posedge rst_n);
        @(negedge clk);
        e = errors;
        expect_low("sq_full", sq_full);
        expect_low("dmem_write", dmem_write);
        expect_low("cdb_store_valid", cdb_store_valid);
        finish_test("reset", e);

        e = errors;
        for (int i = 0; i < 12; i++) issue_store(1'b0, $random(seed));
        drain();
        finish_test("aligned stores", e);

        // rs2 waits on the CDB and port 3 beats port 1
        e = errors;
        issue_store(1'b1, 32'hc3d2_e1f0);
        repeat (6) begin
            @(negedge clk);
            expect_low("dmem_write", dmem_write);
        end
        @(posedge clk);
        {cdb_valid[1], cdb_valid[3]} <= 2'b11;
        {cdb_rob[1], cdb_rob[3]} <= {3'd5, 3'd5};
        cdb_value[1] <= 32'h1111_2222;
        cdb_value[3] <= 32'hc3d2_e1f0;
        @(posedge clk);
        {cdb_valid[1], cdb_valid[3]} <= 2'b00;
        drain();
        finish_test("cdb capture", e);

        e = errors;
        block <= 1'b1;
        for (int i = 0; i < 3; i++) issue_store(1'b0, $random(seed));
        repeat (8) begin
            @(negedge clk);
            expect_low("dmem_write", dmem_write);
        end
        block <= 1'b0;
        drain();
        finish_test("rob ordering", e);

        e = errors;
        stall <= 1'b1;
        for (int i = 0; i < 8; i++) issue_store(1'b0, $random(seed));
        @(negedge clk);
        assert (sq_full) else report_mismatch("sq_full", 32'd1, 32'(sq_full));
        stall <= 1'b0;
        drain();
        expect_low("sq_full", sq_full);
        finish_test("full queue", e);

        e = errors;
        stall <= 1'b1;
        for (int i = 0; i < 3; i++) issue_store(1'b0, $random(seed));
        while (!dmem_write) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        stall <= 1'b0;
        repeat (6) begin
            @(negedge clk);
            expect_low("dmem_write", dmem_write);
        end
        issue_ctr = head_rob;
        for (int i = 0; i < 4; i++) issue_store(1'b0, $random(seed));
        drain();
        finish_test("flush", e);

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end
endmodule

`default_nettype wire
